// File: verilog.f
+incdir+hw
hw/axi_cmd_pkg.sv
hw/axi_write_ctrl.sv
hw/shifter_cmd_regs.sv
hw/axi_read_resp.sv
hw/axi_cmd_bridge.sv
verification/tb_axi_cmd_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi_cmd_bridge
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: verification/tb_axi_cmd_bridge.sv
`timescale 1ns/1ps

`include "axi_cmd_settings.svh"

module tb_axi_cmd_bridge;

    //////////////////////////////////////////////////////////////////////
    // Run limits
    //////////////////////////////////////////////////////////////////////
    localparam int CLK_NS          = 8;
    localparam int NUM_TESTS       = 6;
    localparam int MAX_BEATS       = 4;
    localparam int CYCLES_PER_BEAT = 10;
    localparam int WATCHDOG_NS     = NUM_TESTS * MAX_BEATS * CYCLES_PER_BEAT * CLK_NS + 1000;
    // Bound on any single handshake wait, in cycles
    localparam int WAIT_LIMIT      = 20;

    // Flags that wait_flag can poll
    localparam int CH_AWREADY = 0;
    localparam int CH_WREADY  = 1;
    localparam int CH_BVALID  = 2;
    localparam int CH_ARREADY = 3;
    localparam int CH_RVALID  = 4;

    // One set pulse, value zero extended to the widest command
    typedef struct packed {
        axi_cmd_pkg::cmd_sel_t   sel;
        logic [`DELAY_WIDTH-1:0] value;
    } pulse_t;

    typedef struct packed {
        axi_cmd_pkg::cmd_sel_t   sel;
        logic [`DELAY_WIDTH-1:0] value;
        axi_cmd_pkg::axi_resp_t  resp;
    } expect_t;

    logic                       s_axi_aclk;
    logic                       s_axi_aresetn;
    logic [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
    logic [`AXI_ID_WIDTH-1:0]   s_axi_awid;
    logic                       s_axi_awvalid;
    logic                       s_axi_awready;
    logic [`AXI_DATA_WIDTH-1:0] s_axi_wdata;
    logic                       s_axi_wvalid;
    logic                       s_axi_wlast;
    logic                       s_axi_wready;
    logic                       s_axi_bvalid;
    logic                       s_axi_bready;
    logic [1:0]                 s_axi_bresp;
    logic [`AXI_ID_WIDTH-1:0]   s_axi_bid;
    logic [`AXI_ADDR_WIDTH-1:0] s_axi_araddr;
    logic [`AXI_ID_WIDTH-1:0]   s_axi_arid;
    logic                       s_axi_arvalid;
    logic                       s_axi_arready;
    logic                       s_axi_rvalid;
    logic                       s_axi_rready;
    logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata;
    logic [1:0]                 s_axi_rresp;
    logic                       s_axi_rlast;
    logic [`AXI_ID_WIDTH-1:0]   s_axi_rid;
    logic                       reset;
    logic [`DELAY_WIDTH-1:0]    delay_value;
    logic                       delay_set;
    logic [`EVENT_WIDTH-1:0]    event_value;
    logic                       event_set;
    logic                       polarity_value;
    logic                       polarity_set;

    logic [15:0] lfsr_state;
    pulse_t      exp_q[$];
    pulse_t      seen_q[$];
    int          errors;
    int          start_errors;
    int          tests_run;
    int          tests_passed;

    axi_cmd_bridge u_axi_cmd_bridge (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awid     (s_axi_awid),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wlast    (s_axi_wlast),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bid      (s_axi_bid),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arid     (s_axi_arid),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rlast    (s_axi_rlast),
        .s_axi_rid      (s_axi_rid),
        .reset          (reset),
        .delay_value    (delay_value),
        .delay_set      (delay_set),
        .event_value    (event_value),
        .event_set      (event_set),
        .polarity_value (polarity_value),
        .polarity_set   (polarity_set)
    );

    // 8 ns clock
    initial begin
        s_axi_aclk = 1'b0;
        forever begin
            #(CLK_NS / 2);
            s_axi_aclk = ~s_axi_aclk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and reference model
    //////////////////////////////////////////////////////////////////////
    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit, bits shifted in from the LSB
    task automatic take_bits(input int n, output logic [`AXI_DATA_WIDTH-1:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[`AXI_DATA_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    // Target, value and response that the register map gives for one beat
    function automatic expect_t expected_cmd(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                             input logic [`AXI_DATA_WIDTH-1:0] word);
        expect_t e;
        e.value = '0;
        e.resp  = axi_cmd_pkg::RESP_OKAY;
        if (addr == `ADDR_DELAY) begin
            e.sel   = axi_cmd_pkg::CMD_DELAY;
            e.value = word[`DELAY_WIDTH-1:0];
        end else if (addr == `ADDR_EVENT) begin
            e.sel = axi_cmd_pkg::CMD_EVENT;
            e.value[`EVENT_WIDTH-1:0] = word[`EVENT_WIDTH-1:0];
        end else if (addr == `ADDR_POLARITY) begin
            e.sel = axi_cmd_pkg::CMD_POLARITY;
            e.value[0] = word[0];
        end else begin
            // Unmapped, beats dropped
            e.sel  = axi_cmd_pkg::CMD_NONE;
            e.resp = axi_cmd_pkg::RESP_SLVERR;
        end
        return e;
    endfunction

    function automatic string value_name(input axi_cmd_pkg::cmd_sel_t sel);
        case (sel)
            axi_cmd_pkg::CMD_DELAY: return "delay_value";
            axi_cmd_pkg::CMD_EVENT: return "event_value";
            axi_cmd_pkg::CMD_POLARITY: return "polarity_value";
            default: return "no target";
        endcase
    endfunction

    // Monitor, mid cycle so the registered pulses are settled
    always @(negedge s_axi_aclk) begin
        pulse_t p;
        if (delay_set) begin
            p.sel   = axi_cmd_pkg::CMD_DELAY;
            p.value = delay_value;
            seen_q.push_back(p);
        end
        if (event_set) begin
            p.sel   = axi_cmd_pkg::CMD_EVENT;
            p.value = '0;
            p.value[`EVENT_WIDTH-1:0] = event_value;
            seen_q.push_back(p);
        end
        if (polarity_set) begin
            p.sel      = axi_cmd_pkg::CMD_POLARITY;
            p.value    = '0;
            p.value[0] = polarity_value;
            seen_q.push_back(p);
        end
    end

    // Watchdog sized from the test count
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Check helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [`AXI_DATA_WIDTH-1:0] got,
                               input logic [`AXI_DATA_WIDTH-1:0] exp);
        assert (got === exp) else begin
            $display("ERROR %s expected 0x%0h got 0x%0h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    function automatic logic ch_flag(input int ch);
        case (ch)
            CH_AWREADY: return s_axi_awready;
            CH_WREADY: return s_axi_wready;
            CH_BVALID: return s_axi_bvalid;
            CH_ARREADY: return s_axi_arready;
            default: return s_axi_rvalid;
        endcase
    endfunction

    // Polled 1 ns after the edge, returns in the cycle the flag is high
    task automatic wait_flag(input int ch, input string name);
        int n;
        n = 0;
        while (!ch_flag(ch) && n < WAIT_LIMIT) begin
            @(posedge s_axi_aclk);
            #1;
            n++;
        end
        check_true(ch_flag(ch), $sformatf("%s stayed low for %0d cycles", name, WAIT_LIMIT));
    endtask

    // Recorded pulses against the reference, in order
    task automatic check_pulses();
        pulse_t e;
        pulse_t s;
        repeat (2) @(posedge s_axi_aclk);
        #1;
        check_true(seen_q.size() == exp_q.size(),
                   $sformatf("expected %0d set pulses but saw %0d", exp_q.size(), seen_q.size()));
        while (exp_q.size() > 0 && seen_q.size() > 0) begin
            e = exp_q.pop_front();
            s = seen_q.pop_front();
            check_true(s.sel == e.sel, $sformatf("set pulse on %s where %s was expected",
                       value_name(s.sel), value_name(e.sel)));
            check_value(value_name(e.sel), 128'(s.value), 128'(e.value));
        end
        exp_q.delete();
        seen_q.delete();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus transactions
    //////////////////////////////////////////////////////////////////////
    // lsb below zero leaves bit 0 random
    task automatic write_burst(input logic [`AXI_ADDR_WIDTH-1:0] addr, input int beats,
                               input int bdelay, input int lsb);
        logic [`AXI_DATA_WIDTH-1:0] v;
        logic [`AXI_ID_WIDTH-1:0]   id;
        expect_t                    e;
        pulse_t                     p;
        int                         i;
        take_bits(`AXI_ID_WIDTH, v);
        id            = v[`AXI_ID_WIDTH-1:0];
        s_axi_awaddr  = addr;
        s_axi_awid    = id;
        s_axi_awvalid = 1'b1;
        wait_flag(CH_AWREADY, "awready");
        @(posedge s_axi_aclk);
        #1;
        s_axi_awvalid = 1'b0;
        for (i = 0; i < beats; i++) begin
            take_bits(`AXI_DATA_WIDTH, v);
            if (lsb >= 0) begin
                v[0] = lsb[0];
            end
            e = expected_cmd(addr, v);
            if (e.sel != axi_cmd_pkg::CMD_NONE) begin
                p.sel   = e.sel;
                p.value = e.value;
                exp_q.push_back(p);
            end
            s_axi_wdata  = v;
            s_axi_wvalid = 1'b1;
            s_axi_wlast  = (i == beats - 1);
            wait_flag(CH_WREADY, "wready");
            @(posedge s_axi_aclk);
            #1;
        end
        s_axi_wvalid = 1'b0;
        s_axi_wlast  = 1'b0;
        // Response held while bready lags
        wait_flag(CH_BVALID, "bvalid");
        repeat (bdelay) begin
            check_true(s_axi_bvalid, "bvalid dropped before bready was given");
            @(posedge s_axi_aclk);
            #1;
        end
        s_axi_bready = 1'b1;
        check_true(s_axi_bvalid, "bvalid low when bready was given");
        check_value("s_axi_bresp", 128'(s_axi_bresp), 128'(e.resp));
        check_value("s_axi_bid", 128'(s_axi_bid), 128'(id));
        @(posedge s_axi_aclk);
        #1;
        s_axi_bready = 1'b0;
        check_true(!s_axi_bvalid, "bvalid still high after the B handshake");
        check_pulses();
    endtask

    task automatic read_single(input int rdelay);
        logic [`AXI_DATA_WIDTH-1:0] v;
        logic [`AXI_ID_WIDTH-1:0]   id;
        take_bits(`AXI_ID_WIDTH + `AXI_ADDR_WIDTH, v);
        id            = v[`AXI_ID_WIDTH-1:0];
        s_axi_arid    = id;
        s_axi_araddr  = v[`AXI_ID_WIDTH +: `AXI_ADDR_WIDTH];
        s_axi_arvalid = 1'b1;
        wait_flag(CH_ARREADY, "arready");
        @(posedge s_axi_aclk);
        #1;
        s_axi_arvalid = 1'b0;
        wait_flag(CH_RVALID, "rvalid");
        repeat (rdelay) begin
            check_true(s_axi_rvalid, "rvalid dropped before rready was given");
            @(posedge s_axi_aclk);
            #1;
        end
        s_axi_rready = 1'b1;
        check_true(s_axi_rvalid, "rvalid low when rready was given");
        check_value("s_axi_rdata", s_axi_rdata, '0);
        check_value("s_axi_rresp", 128'(s_axi_rresp), 128'(axi_cmd_pkg::RESP_OKAY));
        check_value("s_axi_rlast", 128'(s_axi_rlast), 128'd1);
        check_value("s_axi_rid", 128'(s_axi_rid), 128'(id));
        @(posedge s_axi_aclk);
        #1;
        s_axi_rready = 1'b0;
        check_true(!s_axi_rvalid, "a second read beat followed the first");
    endtask

    task automatic start_test();
        start_errors = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - start_errors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [`AXI_DATA_WIDTH-1:0] v;
        lfsr_state    = 16'd39;
        errors        = 0;
        start_errors  = 0;
        tests_run     = 0;
        tests_passed  = 0;
        s_axi_aresetn = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awid    = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_wlast   = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arid    = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (2) @(posedge s_axi_aclk);
        #1;

        start_test();
        check_value("reset", 128'(reset), 128'd1);
        s_axi_aresetn = 1'b1;
        @(posedge s_axi_aclk);
        #1;
        check_value("reset", 128'(reset), 128'd0);
        check_value("s_axi_awready", 128'(s_axi_awready), 128'd1);
        check_value("s_axi_arready", 128'(s_axi_arready), 128'd1);
        check_value("s_axi_bvalid", 128'(s_axi_bvalid), 128'd0);
        check_value("s_axi_rvalid", 128'(s_axi_rvalid), 128'd0);
        check_value("delay_set", 128'(delay_set), 128'd0);
        check_value("event_set", 128'(event_set), 128'd0);
        check_value("polarity_set", 128'(polarity_set), 128'd0);
        end_test("reset state");

        start_test();
        take_bits(2, v);
        write_burst(`ADDR_DELAY, 1, int'(v[1:0]), -1);
        end_test("single delay write");

        start_test();
        take_bits(4, v);
        write_burst(`ADDR_EVENT, int'(v[3:2]) + 1, int'(v[1:0]), -1);
        end_test("event burst");

        start_test();
        write_burst(`ADDR_POLARITY, 1, 0, 1);
        write_burst(`ADDR_POLARITY, 1, 0, 0);
        end_test("polarity writes");

        start_test();
        take_bits(4, v);
        write_burst(6'h08, int'(v[3:2]) + 1, int'(v[1:0]), -1);
        end_test("unmapped address");

        start_test();
        take_bits(2, v);
        read_single(int'(v[1:0]));
        end_test("read");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: hw/axi_cmd_bridge.sv
`timescale 1ns/1ps

`include "axi_cmd_settings.svh"

module axi_cmd_bridge (
    //////////////////////////////////////////////////////////////////////
    // Clock and reset
    //////////////////////////////////////////////////////////////////////
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,

    //////////////////////////////////////////////////////////////////////
    // AXI4 write channels
    //////////////////////////////////////////////////////////////////////
    input  logic [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [`AXI_ID_WIDTH-1:0]   s_axi_awid,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,
    input  logic [`AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic                       s_axi_wvalid,
    input  logic                       s_axi_wlast,
    output logic                       s_axi_wready,
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    output logic [1:0]                 s_axi_bresp,
    output logic [`AXI_ID_WIDTH-1:0]   s_axi_bid,

    //////////////////////////////////////////////////////////////////////
    // AXI4 read channels
    //////////////////////////////////////////////////////////////////////
    // Address not decoded, every read answers zero
    input  logic [`AXI_ADDR_WIDTH-1:0] s_axi_araddr,
    input  logic [`AXI_ID_WIDTH-1:0]   s_axi_arid,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,
    output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0]                 s_axi_rresp,
    output logic                       s_axi_rlast,
    output logic [`AXI_ID_WIDTH-1:0]   s_axi_rid,

    //////////////////////////////////////////////////////////////////////
    // Signal shifter commands
    //////////////////////////////////////////////////////////////////////
    output logic                       reset,
    output logic [`DELAY_WIDTH-1:0]    delay_value,
    output logic                       delay_set,
    output logic [`EVENT_WIDTH-1:0]    event_value,
    output logic                       event_set,
    output logic                       polarity_value,
    output logic                       polarity_set
);

    // Accepted beats from write FSM to command registers
    logic                   beat_valid;
    axi_cmd_pkg::cmd_sel_t  beat_sel;
    axi_cmd_pkg::cmd_word_u beat_word;

    // AW, W and B handling
    axi_write_ctrl u_write_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awid    (s_axi_awid),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wlast   (s_axi_wlast),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bid     (s_axi_bid),
        .beat_valid    (beat_valid),
        .beat_sel      (beat_sel),
        .beat_word     (beat_word)
    );

    // One cycle set pulses toward the shifter
    shifter_cmd_regs u_cmd_regs (
        .s_axi_aclk     (s_axi_aclk),
        .s_axi_aresetn  (s_axi_aresetn),
        .beat_valid     (beat_valid),
        .beat_sel       (beat_sel),
        .beat_word      (beat_word),
        .reset          (reset),
        .delay_value    (delay_value),
        .delay_set      (delay_set),
        .event_value    (event_value),
        .event_set      (event_set),
        .polarity_value (polarity_value),
        .polarity_set   (polarity_set)
    );

    // AR and R handling
    axi_read_resp u_read_resp (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .s_axi_arid    (s_axi_arid),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rlast   (s_axi_rlast),
        .s_axi_rid     (s_axi_rid)
    );

endmodule

// File: hw/axi_read_resp.sv
`timescale 1ns/1ps

`include "axi_cmd_settings.svh"

module axi_read_resp (
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,

    // Read address
    input  logic [`AXI_ID_WIDTH-1:0]   s_axi_arid,
    input  logic                       s_axi_arvalid,
    output logic                       s_axi_arready,

    // Read data
    output logic                       s_axi_rvalid,
    input  logic                       s_axi_rready,
    output logic [`AXI_DATA_WIDTH-1:0] s_axi_rdata,
    output axi_cmd_pkg::axi_resp_t     s_axi_rresp,
    output logic                       s_axi_rlast,
    output logic [`AXI_ID_WIDTH-1:0]   s_axi_rid
);

    //////////////////////////////////////////////////////////////////////
    // Two state responder
    //////////////////////////////////////////////////////////////////////
    // Low in idle, high while the R beat is offered
    logic                     rd_busy;
    logic [`AXI_ID_WIDTH-1:0] arid_q;

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            rd_busy <= 1'b0;
        end else if (!rd_busy) begin
            if (s_axi_arvalid) begin
                rd_busy <= 1'b1;
            end
        end else if (s_axi_rready) begin
            rd_busy <= 1'b0;
        end
    end

    // ID echoed back on R
    always_ff @(posedge s_axi_aclk) begin
        if (s_axi_arvalid && s_axi_arready) begin
            arid_q <= s_axi_arid;
        end
    end

    // Single beat of zero, held until rready
    assign s_axi_arready = !rd_busy;
    assign s_axi_rvalid  = rd_busy;
    assign s_axi_rlast   = rd_busy;
    assign s_axi_rdata   = '0;
    assign s_axi_rresp   = axi_cmd_pkg::RESP_OKAY;
    assign s_axi_rid     = arid_q;

endmodule

// File: hw/shifter_cmd_regs.sv
`timescale 1ns/1ps

`include "axi_cmd_settings.svh"

module shifter_cmd_regs (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,

    // Accepted write beat
    input  logic                    beat_valid,
    input  axi_cmd_pkg::cmd_sel_t   beat_sel,
    input  axi_cmd_pkg::cmd_word_u  beat_word,

    // Shifter command outputs
    output logic                    reset,
    output logic [`DELAY_WIDTH-1:0] delay_value,
    output logic                    delay_set,
    output logic [`EVENT_WIDTH-1:0] event_value,
    output logic                    event_set,
    output logic                    polarity_value,
    output logic                    polarity_set
);

    //////////////////////////////////////////////////////////////////////
    // Command registers
    //////////////////////////////////////////////////////////////////////
    // Values only valid in the set cycle, zero otherwise
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            reset          <= 1'b1;
            delay_value    <= '0;
            delay_set      <= 1'b0;
            event_value    <= '0;
            event_set      <= 1'b0;
            polarity_value <= 1'b0;
            polarity_set   <= 1'b0;
        end else begin
            // Shifter leaves reset on the first clock after bus reset
            reset          <= 1'b0;
            delay_value    <= '0;
            delay_set      <= 1'b0;
            event_value    <= '0;
            event_set      <= 1'b0;
            polarity_value <= 1'b0;
            polarity_set   <= 1'b0;
            if (beat_valid) begin
                // Same data word read through the view of the target
                case (beat_sel)
                    axi_cmd_pkg::CMD_DELAY: begin
                        delay_value <= beat_word.delay.value;
                        delay_set   <= 1'b1;
                    end
                    axi_cmd_pkg::CMD_EVENT: begin
                        event_value <= beat_word.events.value;
                        event_set   <= 1'b1;
                    end
                    // Pulse makes a write of 0 visible too
                    axi_cmd_pkg::CMD_POLARITY: begin
                        polarity_value <= beat_word.polarity.value;
                        polarity_set   <= 1'b1;
                    end
                    default: begin
                        // CMD_NONE never forwarded, nothing to set
                    end
                endcase
            end
        end
    end

endmodule

// File: hw/axi_write_ctrl.sv
`timescale 1ns/1ps

`include "axi_cmd_settings.svh"

module axi_write_ctrl (
    input  logic                       s_axi_aclk,
    input  logic                       s_axi_aresetn,

    // Write address
    input  logic [`AXI_ADDR_WIDTH-1:0] s_axi_awaddr,
    input  logic [`AXI_ID_WIDTH-1:0]   s_axi_awid,
    input  logic                       s_axi_awvalid,
    output logic                       s_axi_awready,

    // Write data
    input  logic [`AXI_DATA_WIDTH-1:0] s_axi_wdata,
    input  logic                       s_axi_wvalid,
    input  logic                       s_axi_wlast,
    output logic                       s_axi_wready,

    // Write response
    output logic                       s_axi_bvalid,
    input  logic                       s_axi_bready,
    output axi_cmd_pkg::axi_resp_t     s_axi_bresp,
    output logic [`AXI_ID_WIDTH-1:0]   s_axi_bid,

    // Beats toward the command registers
    output logic                       beat_valid,
    output axi_cmd_pkg::cmd_sel_t      beat_sel,
    output axi_cmd_pkg::cmd_word_u     beat_word
);

    //////////////////////////////////////////////////////////////////////
    // FSM encoding
    //////////////////////////////////////////////////////////////////////
    // Mapped address burst
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_DATA  = 2'd1;
    // Unmapped address burst, beats swallowed
    localparam logic [1:0] ST_DRAIN = 2'd2;
    // B held until bready
    localparam logic [1:0] ST_RESP  = 2'd3;

    logic [1:0]                     state;
    axi_cmd_pkg::cmd_sel_t          addr_sel;
    axi_cmd_pkg::cmd_sel_t          sel_q;
    logic [`AXI_ID_WIDTH-1:0]       id_q;
    logic                           aw_hs;
    logic                           w_hs;
    logic                           b_hs;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////
    // Exact match on the three offsets
    always_comb begin
        case (s_axi_awaddr)
            `ADDR_DELAY: begin
                addr_sel = axi_cmd_pkg::CMD_DELAY;
            end
            `ADDR_EVENT: begin
                addr_sel = axi_cmd_pkg::CMD_EVENT;
            end
            `ADDR_POLARITY: begin
                addr_sel = axi_cmd_pkg::CMD_POLARITY;
            end
            default: begin
                addr_sel = axi_cmd_pkg::CMD_NONE;
            end
        endcase
    end

    // Channel handshakes
    assign aw_hs = s_axi_awvalid && s_axi_awready;
    assign w_hs  = s_axi_wvalid && s_axi_wready;
    assign b_hs  = s_axi_bvalid && s_axi_bready;

    //////////////////////////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Target picked on the AW handshake
                    if (aw_hs) begin
                        if (addr_sel == axi_cmd_pkg::CMD_NONE) begin
                            state <= ST_DRAIN;
                        end else begin
                            state <= ST_DATA;
                        end
                    end
                end
                ST_DATA, ST_DRAIN: begin
                    // Burst ends on wlast only, length is not tracked
                    if (w_hs && s_axi_wlast) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (b_hs) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Target and ID of the current burst
    always_ff @(posedge s_axi_aclk) begin
        if (aw_hs) begin
            sel_q <= addr_sel;
            id_q  <= s_axi_awid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Channel outputs
    //////////////////////////////////////////////////////////////////////
    // No new AW while a burst or its response is pending
    assign s_axi_awready = (state == ST_IDLE);
    assign s_axi_wready  = (state == ST_DATA) || (state == ST_DRAIN);
    assign s_axi_bvalid  = (state == ST_RESP);
    assign s_axi_bid     = id_q;
    // Unmapped bursts leave sel_q at CMD_NONE
    assign s_axi_bresp   = (sel_q == axi_cmd_pkg::CMD_NONE) ? axi_cmd_pkg::RESP_SLVERR
                                                              : axi_cmd_pkg::RESP_OKAY;

    // Beat forwarded in the handshake cycle itself
    assign beat_valid = (state == ST_DATA) && s_axi_wvalid;
    assign beat_sel   = sel_q;
    assign beat_word  = s_axi_wdata;

endmodule

// File: hw/axi_cmd_pkg.sv
`include "axi_cmd_settings.svh"

package axi_cmd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Command target of one write beat
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        CMD_NONE     = 2'd0,
        CMD_DELAY    = 2'd1,
        CMD_EVENT    = 2'd2,
        CMD_POLARITY = 2'd3
    } cmd_sel_t;

    // AXI response code, only the two used here
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    //////////////////////////////////////////////////////////////////////
    // Write data word, seen per target
    //////////////////////////////////////////////////////////////////////
    // Every field starts at bit 0, upper bits ignored
    typedef union packed {
        struct packed {
            logic [`AXI_DATA_WIDTH-`DELAY_WIDTH-1:0] pad;
            logic [`DELAY_WIDTH-1:0]                 value;
        } delay;
        struct packed {
            logic [`AXI_DATA_WIDTH-`EVENT_WIDTH-1:0] pad;
            logic [`EVENT_WIDTH-1:0]                 value;
        } events;
        // Polarity is the LSB alone
        struct packed {
            logic [`AXI_DATA_WIDTH-2:0] pad;
            logic                       value;
        } polarity;
    } cmd_word_u;

endpackage

// File: hw/axi_cmd_settings.svh
`ifndef AXI_CMD_SETTINGS_SVH
`define AXI_CMD_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// AXI4 bus widths
//////////////////////////////////////////////////////////////////////

// Byte address, covers the 0x00..0x3F register window
`define AXI_ADDR_WIDTH 6
`define AXI_DATA_WIDTH 128
`define AXI_ID_WIDTH   16

//////////////////////////////////////////////////////////////////////
// Shifter command widths
//////////////////////////////////////////////////////////////////////

// Delay up to 1,000,000,000 cycles
`define DELAY_WIDTH 30
// Up to 1000 events
`define EVENT_WIDTH 10

// Register offsets on the write side
`define ADDR_DELAY    6'h10
`define ADDR_EVENT    6'h20
`define ADDR_POLARITY 6'h30

`endif
